/* hdl/fme_cost_pkg.sv */
// FME cost shared definitions
`default_nettype none

package fme_cost_pkg;

    // **************************************************
    // widths
    // **************************************************
    localparam int PIXEL_WIDTH  = 8;
    localparam int FMV_WIDTH    = 10;
    localparam int SATD_WIDTH   = PIXEL_WIDTH + 10;
    localparam int COST_WIDTH   = SATD_WIDTH + 1;
    localparam int LAMBDA_WIDTH = 7;
    // x+y exp-golomb bit count, at most 2*21
    localparam int BITS_WIDTH   = 6;
    localparam int RATE_WIDTH   = 13;
    localparam int NUM_CAND     = 9;
    localparam int IDX_WIDTH    = 4;

    // **************************************************
    // scalar types
    // **************************************************
    typedef logic signed [FMV_WIDTH-1:0] fmv_t;
    typedef logic [SATD_WIDTH-1:0]       satd_t;
    typedef logic [COST_WIDTH-1:0]       cost_t;
    typedef logic [LAMBDA_WIDTH-1:0]     lambda_t;
    typedef logic [RATE_WIDTH-1:0]       rate_t;
    // 3*(dy+1)+(dx+1), center is 4
    typedef logic [IDX_WIDTH-1:0]        cand_idx_t;

    // **************************************************
    // bundles
    // **************************************************
    typedef struct packed {
        fmv_t x;
        fmv_t y;
    } fmv_pair_t;

    // one field per search point, sp0 in the top bits
    typedef struct packed {
        satd_t sp0;
        satd_t sp1;
        satd_t sp2;
        satd_t sp3;
        satd_t sp4;
        satd_t sp5;
        satd_t sp6;
        satd_t sp7;
        satd_t sp8;
    } satd_vec_t;

    typedef struct packed {
        rate_t sp0;
        rate_t sp1;
        rate_t sp2;
        rate_t sp3;
        rate_t sp4;
        rate_t sp5;
        rate_t sp6;
        rate_t sp7;
        rate_t sp8;
    } rate_vec_t;

    typedef struct packed {
        cost_t sp0;
        cost_t sp1;
        cost_t sp2;
        cost_t sp3;
        cost_t sp4;
        cost_t sp5;
        cost_t sp6;
        cost_t sp7;
        cost_t sp8;
    } cost_vec_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        DECIDE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/fme_cost_ctrl.sv */
// FME cost control FSM
`timescale 1ns/100ps
`default_nettype none

module fme_cost_ctrl (
    input  wire  clk,
    input  wire  rstn,
    input  wire  cost_start_i,
    input  wire  satd_valid_i,
    input  wire  pu_last_i,
    output logic acc_clear_o,
    output logic acc_en_o,
    output logic add_rate_o,
    output logic decide_o
);

    fme_cost_pkg::ctrl_state_t state;
    fme_cost_pkg::ctrl_state_t state_nxt;

    // **************************************************
    // state register
    // **************************************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= fme_cost_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            fme_cost_pkg::ACCUM: begin
                if (acc_en_o && pu_last_i) begin
                    state_nxt = fme_cost_pkg::DECIDE;
                end
            end
            fme_cost_pkg::DECIDE: begin
                state_nxt = fme_cost_pkg::IDLE;
            end
            default: begin
                state_nxt = state;
            end
        endcase
        // a new PU wins from any state
        if (cost_start_i) begin
            state_nxt = fme_cost_pkg::ACCUM;
        end
    end

    // **************************************************
    // command strobes
    // **************************************************
    assign acc_clear_o = cost_start_i;
    // beat that coincides with a start is dropped
    assign acc_en_o    = satd_valid_i && !cost_start_i && (state == fme_cost_pkg::ACCUM);
    assign add_rate_o  = acc_en_o && pu_last_i;
    assign decide_o    = (state == fme_cost_pkg::DECIDE);

endmodule

`default_nettype wire

/* hdl/mv_rate_calc.sv */
// MV rate per search point
`timescale 1ns/100ps
`default_nettype none

module mv_rate_calc (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire fme_cost_pkg::fmv_pair_t   mv_i,
    input  wire                            half_ip_flag_i,
    input  wire fme_cost_pkg::lambda_t     lambda_i,
    output fme_cost_pkg::rate_vec_t        rate_o
);

    // exp-golomb length of one signed mvd component, predictor is zero
    function automatic logic [fme_cost_pkg::BITS_WIDTH-1:0] eg_bits(
        input fme_cost_pkg::fmv_t d
    );
        logic signed [fme_cost_pkg::FMV_WIDTH:0] d_ext;
        logic [fme_cost_pkg::FMV_WIDTH:0]        mag;
        logic [fme_cost_pkg::FMV_WIDTH+1:0]      code_p1;
        logic [fme_cost_pkg::BITS_WIDTH-1:0]     msb;
        d_ext = d;
        mag   = d_ext[fme_cost_pkg::FMV_WIDTH] ? -d_ext : d_ext;
        // code+1 is 2|d|+1 for d>=0, 2|d|+2 for d<0
        code_p1 = {mag, 1'b0} + (d_ext[fme_cost_pkg::FMV_WIDTH] ? 2'd2 : 2'd1);
        msb = '0;
        for (int i = 0; i < fme_cost_pkg::FMV_WIDTH + 2; i++) begin
            if (code_p1[i]) begin
                msb = i[fme_cost_pkg::BITS_WIDTH-1:0];
            end
        end
        // 2*floor(log2(code+1))+1
        return {msb[fme_cost_pkg::BITS_WIDTH-2:0], 1'b1};
    endfunction

    fme_cost_pkg::fmv_t                       step;
    logic [fme_cost_pkg::BITS_WIDTH-1:0]      bits_x [0:2];
    logic [fme_cost_pkg::BITS_WIDTH-1:0]      bits_y [0:2];
    logic [fme_cost_pkg::BITS_WIDTH-1:0]      bits_sum [0:fme_cost_pkg::NUM_CAND-1];
    fme_cost_pkg::rate_t [0:fme_cost_pkg::NUM_CAND-1] rate_a;

    // **************************************************
    // per-axis bit counts, offsets -1/0/+1 step
    // **************************************************
    always_comb begin
        step      = half_ip_flag_i ? fme_cost_pkg::fmv_t'(2) : fme_cost_pkg::fmv_t'(1);
        bits_x[0] = eg_bits(mv_i.x - step);
        bits_x[1] = eg_bits(mv_i.x);
        bits_x[2] = eg_bits(mv_i.x + step);
        bits_y[0] = eg_bits(mv_i.y - step);
        bits_y[1] = eg_bits(mv_i.y);
        bits_y[2] = eg_bits(mv_i.y + step);
    end

    // pairwise sums, registered
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int k = 0; k < fme_cost_pkg::NUM_CAND; k++) begin
                bits_sum[k] <= '0;
            end
        end else begin
            for (int j = 0; j < 3; j++) begin
                for (int i = 0; i < 3; i++) begin
                    bits_sum[3*j+i] <= bits_x[i] + bits_y[j];
                end
            end
        end
    end

    // lambda weighting
    always_comb begin
        for (int k = 0; k < fme_cost_pkg::NUM_CAND; k++) begin
            rate_a[k] = lambda_i * bits_sum[k];
        end
    end

    assign rate_o = rate_a;

endmodule

`default_nettype wire

/* hdl/satd_accum.sv */
// SATD and rate accumulators
`timescale 1ns/100ps
`default_nettype none

module satd_accum (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            clear_i,
    input  wire                            en_i,
    input  wire                            add_rate_i,
    input  wire fme_cost_pkg::satd_vec_t   satd_i,
    input  wire fme_cost_pkg::rate_vec_t   rate_i,
    output fme_cost_pkg::cost_vec_t        cost_o
);

    // ascending ranges keep sp0 at element 0
    fme_cost_pkg::satd_t [0:fme_cost_pkg::NUM_CAND-1] satd_a;
    fme_cost_pkg::rate_t [0:fme_cost_pkg::NUM_CAND-1] rate_a;
    fme_cost_pkg::cost_t [0:fme_cost_pkg::NUM_CAND-1] acc;

    assign satd_a = satd_i;
    assign rate_a = rate_i;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc <= '0;
        end else if (clear_i) begin
            acc <= '0;
        end else if (en_i) begin
            for (int k = 0; k < fme_cost_pkg::NUM_CAND; k++) begin
                // rate only once, on the last block
                acc[k] <= acc[k] + satd_a[k] + (add_rate_i ? rate_a[k] : '0);
            end
        end
    end

    assign cost_o = acc;

endmodule

`default_nettype wire

/* hdl/best_cand_sel.sv */
// best search point selection
`timescale 1ns/100ps
`default_nettype none

module best_cand_sel (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            decide_i,
    input  wire fme_cost_pkg::cost_vec_t   cost_i,
    input  wire fme_cost_pkg::fmv_pair_t   mv_i,
    input  wire                            half_ip_flag_i,
    output fme_cost_pkg::cost_t            best_cost_o,
    output fme_cost_pkg::cand_idx_t        best_sp_o,
    output fme_cost_pkg::fmv_pair_t        fmv_best_o,
    output logic                           cost_done_o
);

    fme_cost_pkg::cost_t [0:fme_cost_pkg::NUM_CAND-1] cost_a;
    fme_cost_pkg::cost_t     min_cost;
    fme_cost_pkg::cand_idx_t min_idx;
    fme_cost_pkg::fmv_t      off_x;
    fme_cost_pkg::fmv_t      off_y;
    fme_cost_pkg::fmv_t      delta_x;
    fme_cost_pkg::fmv_t      delta_y;
    fme_cost_pkg::fmv_pair_t best_mv;

    assign cost_a = cost_i;

    // **************************************************
    // nine-way minimum
    // **************************************************
    always_comb begin
        min_cost = cost_a[0];
        min_idx  = '0;
        off_x    = fme_cost_pkg::fmv_t'(-1);
        off_y    = fme_cost_pkg::fmv_t'(-1);
        for (int j = 0; j < 3; j++) begin
            for (int i = 0; i < 3; i++) begin
                // strict compare, lower index keeps a tie
                if (cost_a[3*j+i] < min_cost) begin
                    min_cost = cost_a[3*j+i];
                    min_idx  = fme_cost_pkg::cand_idx_t'(3*j+i);
                    off_x    = fme_cost_pkg::fmv_t'(i - 1);
                    off_y    = fme_cost_pkg::fmv_t'(j - 1);
                end
            end
        end
        // half-pel search steps by two quarter-pel units
        delta_x   = half_ip_flag_i ? (off_x <<< 1) : off_x;
        delta_y   = half_ip_flag_i ? (off_y <<< 1) : off_y;
        best_mv.x = mv_i.x + delta_x;
        best_mv.y = mv_i.y + delta_y;
    end

    // **************************************************
    // result registers
    // **************************************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            best_cost_o <= '0;
            best_sp_o   <= '0;
            fmv_best_o  <= '0;
            cost_done_o <= 1'b0;
        end else begin
            cost_done_o <= decide_i;
            if (decide_i) begin
                best_cost_o <= min_cost;
                best_sp_o   <= min_idx;
                fmv_best_o  <= best_mv;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fme_cost.sv */
// FME cost stage top
`timescale 1ns/100ps
`default_nettype none

module fme_cost (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            cost_start_i,
    input  wire                            satd_valid_i,
    input  wire                            pu_last_i,
    input  wire fme_cost_pkg::satd_vec_t   satd_i,
    input  wire fme_cost_pkg::fmv_pair_t   mv_i,
    input  wire                            half_ip_flag_i,
    input  wire fme_cost_pkg::lambda_t     lambda_i,
    output wire                            cost_done_o,
    output wire fme_cost_pkg::cost_t       best_cost_o,
    output wire fme_cost_pkg::cand_idx_t   best_sp_o,
    output wire fme_cost_pkg::fmv_pair_t   fmv_best_o
);

    logic                    acc_clear;
    logic                    acc_en;
    logic                    add_rate;
    logic                    decide;
    fme_cost_pkg::rate_vec_t rate_vec;
    fme_cost_pkg::cost_vec_t cost_vec;

    // **************************************************
    // control
    // **************************************************
    fme_cost_ctrl i_fme_cost_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .cost_start_i (cost_start_i),
        .satd_valid_i (satd_valid_i),
        .pu_last_i    (pu_last_i),
        .acc_clear_o  (acc_clear),
        .acc_en_o     (acc_en),
        .add_rate_o   (add_rate),
        .decide_o     (decide)
    );

    // **************************************************
    // datapath
    // **************************************************
    mv_rate_calc i_mv_rate_calc (
        .clk            (clk),
        .rstn           (rstn),
        .mv_i           (mv_i),
        .half_ip_flag_i (half_ip_flag_i),
        .lambda_i       (lambda_i),
        .rate_o         (rate_vec)
    );

    satd_accum i_satd_accum (
        .clk        (clk),
        .rstn       (rstn),
        .clear_i    (acc_clear),
        .en_i       (acc_en),
        .add_rate_i (add_rate),
        .satd_i     (satd_i),
        .rate_i     (rate_vec),
        .cost_o     (cost_vec)
    );

    best_cand_sel i_best_cand_sel (
        .clk            (clk),
        .rstn           (rstn),
        .decide_i       (decide),
        .cost_i         (cost_vec),
        .mv_i           (mv_i),
        .half_ip_flag_i (half_ip_flag_i),
        .best_cost_o    (best_cost_o),
        .best_sp_o      (best_sp_o),
        .fmv_best_o     (fmv_best_o),
        .cost_done_o    (cost_done_o)
    );

endmodule

`default_nettype wire

/* sim/clk_gen.sv */
// testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // release just after an edge, clear of the sampling point
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/fme_cost_assertions.sv */
// control strobe assertions
`timescale 1ns/100ps
`default_nettype none

module fme_cost_assertions (
    input wire clk,
    input wire rstn,
    input wire acc_clear_i,
    input wire acc_en_i,
    input wire add_rate_i,
    input wire decide_i
);

    // DECIDE never lasts past one cycle
    decide_single: assert property (
        @(posedge clk) disable iff (!rstn) decide_i |=> !decide_i
    ) else $error("decide strobe held for more than one cycle");

    // the accepted last beat leads straight into the decision cycle
    rate_needs_beat: assert property (
        @(posedge clk) disable iff (!rstn) add_rate_i |-> acc_en_i ##1 decide_i
    ) else $error("add_rate strobe not followed by the decision cycle");

    // a start drops the beat and leads into ACCUM
    clear_excludes_beat: assert property (
        @(posedge clk) disable iff (!rstn) acc_clear_i |-> !acc_en_i ##1 !decide_i
    ) else $error("clear strobe with a beat or followed by a decision");

endmodule

bind fme_cost_ctrl fme_cost_assertions i_fme_cost_assertions (
    .clk         (clk),
    .rstn        (rstn),
    .acc_clear_i (acc_clear_o),
    .acc_en_i    (acc_en_o),
    .add_rate_i  (add_rate_o),
    .decide_i    (decide_o)
);

`default_nettype wire

/* sim/tb_fme_cost.sv */
// FME cost stage testbench
`timescale 1ns/100ps
`default_nettype none

module tb_fme_cost;

    localparam int          CLK_PERIOD  = 40;
    localparam int          TOTAL_BEATS = 16;
    localparam int          DONE_LIMIT  = 20;
    localparam logic [31:0] SEED        = 32'h7b3aec5d;

    logic                      clk;
    logic                      rstn;
    logic                      cost_start;
    logic                      satd_valid;
    logic                      pu_last;
    logic                      half_ip_flag;
    fme_cost_pkg::satd_vec_t   satd;
    fme_cost_pkg::fmv_pair_t   mv;
    fme_cost_pkg::lambda_t     lambda;
    logic                      cost_done;
    fme_cost_pkg::cost_t       best_cost;
    fme_cost_pkg::cand_idx_t   best_sp;
    fme_cost_pkg::fmv_pair_t   fmv_best;

    // reference model state
    int   blk [0:8];
    int   exp_acc [0:8];
    int   ref_mv_x;
    int   ref_mv_y;
    int   ref_lambda;
    logic ref_half;
    int   exp_cost;
    int   exp_sp;
    int   exp_x;
    int   exp_y;

    clk_gen i_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    fme_cost i_fme_cost (
        .clk            (clk),
        .rstn           (rstn),
        .cost_start_i   (cost_start),
        .satd_valid_i   (satd_valid),
        .pu_last_i      (pu_last),
        .satd_i         (satd),
        .mv_i           (mv),
        .half_ip_flag_i (half_ip_flag),
        .lambda_i       (lambda),
        .cost_done_o    (cost_done),
        .best_cost_o    (best_cost),
        .best_sp_o      (best_sp),
        .fmv_best_o     (fmv_best)
    );

    // **************************************************
    // reference model
    // **************************************************
    function automatic int eg_len(input int d);
        int code;
        int v;
        int len;
        code = (d > 0) ? 2 * d : ((d < 0) ? -2 * d + 1 : 0);
        v    = code + 1;
        len  = 0;
        while (v > 1) begin
            v = v >> 1;
            len++;
        end
        return 2 * len + 1;
    endfunction

    function automatic int rate_of(input int k);
        int step;
        step = ref_half ? 2 : 1;
        return ref_lambda * (eg_len(ref_mv_x + ((k % 3) - 1) * step) +
                             eg_len(ref_mv_y + ((k / 3) - 1) * step));
    endfunction

    // lowest index keeps a tie
    task automatic predict_result();
        int step;
        exp_cost = exp_acc[0];
        exp_sp   = 0;
        for (int k = 1; k < 9; k++) begin
            if (exp_acc[k] < exp_cost) begin
                exp_cost = exp_acc[k];
                exp_sp   = k;
            end
        end
        step  = ref_half ? 2 : 1;
        exp_x = ref_mv_x + ((exp_sp % 3) - 1) * step;
        exp_y = ref_mv_y + ((exp_sp / 3) - 1) * step;
    endtask

    // **************************************************
    // drivers and checks
    // **************************************************
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compare_value(input string name, input int got, input int expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, expected);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic fme_cost_pkg::satd_vec_t pack_satd();
        fme_cost_pkg::satd_t [0:8] a;
        for (int k = 0; k < 9; k++) begin
            a[k] = fme_cost_pkg::satd_t'(blk[k]);
        end
        return a;
    endfunction

    function automatic int random_mv();
        return int'($urandom_range(400)) - 200;
    endfunction

    task automatic fill_random_blk(input int lo, input int hi);
        for (int k = 0; k < 9; k++) begin
            blk[k] = int'($urandom_range(hi, lo));
        end
    endtask

    task automatic set_pu_params(input int x, input int y, input logic half, input int lam);
        ref_mv_x     = x;
        ref_mv_y     = y;
        ref_half     = half;
        ref_lambda   = lam;
        mv.x         = fme_cost_pkg::fmv_t'(x);
        mv.y         = fme_cost_pkg::fmv_t'(y);
        half_ip_flag = half;
        lambda       = fme_cost_pkg::lambda_t'(lam);
    endtask

    task automatic start_pu();
        cost_start = 1'b1;
        for (int k = 0; k < 9; k++) begin
            exp_acc[k] = 0;
        end
        next_cycle();
        cost_start = 1'b0;
    endtask

    task automatic send_beat(input logic last);
        satd       = pack_satd();
        satd_valid = 1'b1;
        pu_last    = last;
        for (int k = 0; k < 9; k++) begin
            exp_acc[k] += blk[k] + (last ? rate_of(k) : 0);
        end
        next_cycle();
        satd_valid = 1'b0;
        pu_last    = 1'b0;
    endtask

    // beats the control must ignore, each marked as a last block
    task automatic send_stray(input int n);
        for (int i = 0; i < n; i++) begin
            fill_random_blk(0, 1000);
            satd       = pack_satd();
            satd_valid = 1'b1;
            pu_last    = 1'b1;
            next_cycle();
            satd_valid = 1'b0;
            pu_last    = 1'b0;
            compare_value("cost_done_o during stray beats", int'(cost_done), 0);
        end
        // an accepted stray beat would raise the done strobe here
        next_cycle();
        compare_value("cost_done_o after stray beats", int'(cost_done), 0);
    endtask

    task automatic wait_done(output int edges);
        edges = 0;
        while (cost_done !== 1'b1) begin
            if (edges == DONE_LIMIT) begin
                $display("cost_done_o did not rise within %0d cycles", DONE_LIMIT);
                $display("*** FAILED ***");
                $fatal(1, "no decision from the DUT");
            end
            next_cycle();
            edges++;
        end
    endtask

    task automatic check_result();
        compare_value("best_cost_o", int'(best_cost), exp_cost);
        compare_value("best_sp_o", int'(best_sp), exp_sp);
        compare_value("fmv_best_o.x", int'($signed(fmv_best.x)), exp_x);
        compare_value("fmv_best_o.y", int'($signed(fmv_best.y)), exp_y);
    endtask

    // **************************************************
    // tests
    // **************************************************
    task automatic test_reset();
        compare_value("cost_done_o", int'(cost_done), 0);
        compare_value("best_cost_o", int'(best_cost), 0);
        compare_value("best_sp_o", int'(best_sp), 0);
        compare_value("fmv_best_o", int'(fmv_best), 0);
    endtask

    task automatic test_single_block();
        int edges;
        set_pu_params(37, -12, 1'b0, 0);
        start_pu();
        // sp3 and sp5 tie at the minimum
        blk = '{900, 500, 700, 300, 800, 300, 650, 1000, 400};
        send_beat(1'b1);
        wait_done(edges);
        // beat edge plus the edge that ends DECIDE
        compare_value("cost_done_o edges after last beat", edges + 1, 2);
        predict_result();
        check_result();
        next_cycle();
        compare_value("cost_done_o pulse width", int'(cost_done), 0);
    endtask

    task automatic test_multi_block();
        int edges;
        set_pu_params(random_mv(), random_mv(), 1'b0, int'($urandom_range(127, 1)));
        start_pu();
        for (int b = 0; b < 3; b++) begin
            fill_random_blk(0, 40000);
            send_beat(1'b0);
        end
        fill_random_blk(0, 40000);
        send_beat(1'b1);
        wait_done(edges);
        predict_result();
        check_result();
    endtask

    task automatic test_half_pel();
        int edges;
        int win;
        set_pu_params(random_mv(), random_mv(), 1'b1, int'($urandom_range(20)));
        win = int'($urandom_range(8));
        start_pu();
        for (int b = 0; b < 2; b++) begin
            fill_random_blk(20000, 30000);
            blk[win] = 100;
            send_beat(b == 1);
        end
        wait_done(edges);
        predict_result();
        check_result();
        compare_value("best_sp_o chosen winner", int'(best_sp), win);
    endtask

    task automatic test_back_to_back();
        int edges;
        send_stray(2);
        set_pu_params(random_mv(), random_mv(), 1'b0, int'($urandom_range(127)));
        start_pu();
        for (int b = 0; b < 3; b++) begin
            fill_random_blk(0, 40000);
            send_beat(b == 2);
        end
        // second PU opens in the DECIDE cycle
        predict_result();
        start_pu();
        compare_value("cost_done_o first PU", int'(cost_done), 1);
        check_result();
        set_pu_params(random_mv(), random_mv(), 1'b1, int'($urandom_range(127)));
        for (int b = 0; b < 2; b++) begin
            fill_random_blk(0, 40000);
            send_beat(b == 1);
        end
        wait_done(edges);
        predict_result();
        check_result();
        send_stray(2);
        check_result();
    endtask

    // **************************************************
    // main sequence and watchdog
    // **************************************************
    initial begin
        void'($urandom(SEED));
        cost_start   = 1'b0;
        satd_valid   = 1'b0;
        pu_last      = 1'b0;
        half_ip_flag = 1'b0;
        satd         = '0;
        mv           = '0;
        lambda       = '0;
        @(posedge rstn);
        next_cycle();
        test_reset();
        test_single_block();
        test_multi_block();
        test_half_pel();
        test_back_to_back();
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #((TOTAL_BEATS * 4 + 200) * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("*** FAILED ***");
        $fatal(1, "simulation timeout");
    end

endmodule

`default_nettype wire

/* files.f */
hdl/fme_cost_pkg.sv
hdl/fme_cost_ctrl.sv
hdl/mv_rate_calc.sv
hdl/satd_accum.sv
hdl/best_cand_sel.sv
hdl/fme_cost.sv
sim/clk_gen.sv
sim/fme_cost_assertions.sv
sim/tb_fme_cost.sv

/* Makefile */
# Verilator build for the FME cost stage

VERILATOR  ?= verilator
TOP        ?= tb_fme_cost
RTL_TOP    ?= fme_cost
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS := $(filter hdl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
